/* verilog/execute_pkg.sv */
`default_nettype none

package execute_pkg;

	// ============================================================
	// Widths
	// ============================================================
	localparam int XLEN = 32;
	localparam int TAG_W = 4;
	localparam int REG_W = 5;
	localparam int CLASS_W = 4;
	localparam int ALUOP_W = 4;
	localparam int SEL_W = 3;
	localparam int STATE_W = 2;

	// Instruction classes, codes 8 and up are invalid
	localparam logic [CLASS_W-1:0] CLS_ARITH = 'd0;
	localparam logic [CLASS_W-1:0] CLS_SHIFT = 'd1;
	localparam logic [CLASS_W-1:0] CLS_COMPARE = 'd2;
	localparam logic [CLASS_W-1:0] CLS_JUMP = 'd3;
	localparam logic [CLASS_W-1:0] CLS_BRANCH = 'd4;
	localparam logic [CLASS_W-1:0] CLS_LOAD = 'd5;
	localparam logic [CLASS_W-1:0] CLS_STORE = 'd6;
	localparam logic [CLASS_W-1:0] CLS_MULDIV = 'd7;

	// ============================================================
	// ALU operations
	// ============================================================
	localparam logic [ALUOP_W-1:0] ALU_ADD = 'd0;
	localparam logic [ALUOP_W-1:0] ALU_SUB = 'd1;
	localparam logic [ALUOP_W-1:0] ALU_AND = 'd2;
	localparam logic [ALUOP_W-1:0] ALU_OR = 'd3;
	localparam logic [ALUOP_W-1:0] ALU_XOR = 'd4;
	localparam logic [ALUOP_W-1:0] ALU_SLL = 'd5;
	localparam logic [ALUOP_W-1:0] ALU_SRL = 'd6;
	localparam logic [ALUOP_W-1:0] ALU_SRA = 'd7;
	localparam logic [ALUOP_W-1:0] ALU_SLT = 'd8;
	localparam logic [ALUOP_W-1:0] ALU_SLTU = 'd9;
	localparam logic [ALUOP_W-1:0] ALU_EQ = 'd10;
	localparam logic [ALUOP_W-1:0] ALU_NE = 'd11;
	localparam logic [ALUOP_W-1:0] ALU_GE = 'd12;
	localparam logic [ALUOP_W-1:0] ALU_GEU = 'd13;

	// Same field, reused for the muldiv class
	localparam logic [ALUOP_W-1:0] MD_MUL = 'd0;
	localparam logic [ALUOP_W-1:0] MD_MULH = 'd1;
	localparam logic [ALUOP_W-1:0] MD_MULHU = 'd2;
	localparam logic [ALUOP_W-1:0] MD_MULHSU = 'd3;
	localparam logic [ALUOP_W-1:0] MD_DIV = 'd4;
	localparam logic [ALUOP_W-1:0] MD_DIVU = 'd5;
	localparam logic [ALUOP_W-1:0] MD_REM = 'd6;
	localparam logic [ALUOP_W-1:0] MD_REMU = 'd7;

	// Operand selectors
	localparam logic [SEL_W-1:0] SEL_ZERO = 'd0;
	localparam logic [SEL_W-1:0] SEL_RS1 = 'd1;
	localparam logic [SEL_W-1:0] SEL_RS2 = 'd2;
	localparam logic [SEL_W-1:0] SEL_PC = 'd3;
	localparam logic [SEL_W-1:0] SEL_IMM = 'd4;

	// Control FSM
	localparam logic [STATE_W-1:0] ST_IDLE = 'd0;
	localparam logic [STATE_W-1:0] ST_MUL_WAIT = 'd1;
	localparam logic [STATE_W-1:0] ST_DIV_RUN = 'd2;

	localparam int DIV_STEPS = 32;
	localparam int DIV_CNT_W = $clog2(DIV_STEPS);

	// Full product, or high and low words
	typedef union packed {
		logic [2*XLEN-1:0] word;
		logic [1:0][XLEN-1:0] half;
	} mul_product_u;

endpackage

`default_nettype wire

/* verilog/issue_if.sv */
`default_nettype none

interface issue_if import execute_pkg::*; ();

	logic pending;
	logic [TAG_W-1:0] tag;
	logic [CLASS_W-1:0] op_class;
	logic [ALUOP_W-1:0] alu_op;
	logic [XLEN-1:0] op1;
	logic [XLEN-1:0] op2;
	logic [XLEN-1:0] rs1;
	logic [XLEN-1:0] rs2;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] imm;
	logic [REG_W-1:0] rd;
	logic [1:0] mem_width;
	logic mem_signed;

	// Retire pulse from the control block
	logic done;

	modport issue (
		output pending, tag, op_class, alu_op, op1, op2, rs1, rs2, pc, imm, rd,
		output mem_width, mem_signed,
		input done
	);

	modport exec (
		input pending, tag, op_class, alu_op, op1, op2, rs1, rs2, pc, imm, rd,
		input mem_width, mem_signed,
		output done
	);

endinterface

`default_nettype wire

/* verilog/alu.sv */
`default_nettype none

module alu import execute_pkg::*; (
	input wire [ALUOP_W-1:0] i_op,
	input wire [XLEN-1:0] i_op1,
	input wire [XLEN-1:0] i_op2,
	output logic [XLEN-1:0] o_result,
	output logic [XLEN-1:0] o_sum,
	output logic o_compare
);

	logic [4:0] shamt;

	assign shamt = i_op2[4:0];

	// Address and target adder
	assign o_sum = XLEN'($signed(i_op1) + $signed(i_op2));

	always_comb begin
		case (i_op)
			ALU_SLT: o_compare = $signed(i_op1) < $signed(i_op2);
			ALU_SLTU: o_compare = i_op1 < i_op2;
			ALU_EQ: o_compare = i_op1 == i_op2;
			ALU_NE: o_compare = i_op1 != i_op2;
			ALU_GE: o_compare = $signed(i_op1) >= $signed(i_op2);
			ALU_GEU: o_compare = i_op1 >= i_op2;
			default: o_compare = 1'b0;
		endcase
	end

	always_comb begin
		case (i_op)
			ALU_ADD: o_result = i_op1 + i_op2;
			ALU_SUB: o_result = i_op1 - i_op2;
			ALU_AND: o_result = i_op1 & i_op2;
			ALU_OR: o_result = i_op1 | i_op2;
			ALU_XOR: o_result = i_op1 ^ i_op2;
			ALU_SLL: o_result = i_op1 << shamt;
			ALU_SRL: o_result = i_op1 >> shamt;
			ALU_SRA: o_result = XLEN'($signed(i_op1) >>> shamt);
			ALU_SLT,
			ALU_SLTU,
			ALU_EQ,
			ALU_NE,
			ALU_GE,
			ALU_GEU: o_result = {{(XLEN-1){1'b0}}, o_compare};
			default: o_result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/multiplier.sv */
`default_nettype none

module multiplier import execute_pkg::*; (
	input wire i_clock,
	input wire i_sign1,
	input wire i_sign2,
	input wire [XLEN-1:0] i_op1,
	input wire [XLEN-1:0] i_op2,
	output mul_product_u o_product
);

	logic signed [XLEN:0] op1_q;
	logic signed [XLEN:0] op2_q;
	logic signed [2*XLEN+1:0] full_product;

	// 33 by 33 covers signed, unsigned and mixed forms
	assign full_product = op1_q * op2_q;

	always_ff @(posedge i_clock) begin
		op1_q <= {i_sign1 & i_op1[XLEN-1], i_op1};
		op2_q <= {i_sign2 & i_op2[XLEN-1], i_op2};
	end

	always_ff @(posedge i_clock) begin
		o_product.word <= full_product[2*XLEN-1:0];
	end

endmodule

`default_nettype wire

/* verilog/divider.sv */
`default_nettype none

module divider import execute_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	input wire i_start,
	input wire i_signed,
	input wire [XLEN-1:0] i_numerator,
	input wire [XLEN-1:0] i_denominator,
	output logic o_done,
	output logic [XLEN-1:0] o_quotient,
	output logic [XLEN-1:0] o_remainder
);

	logic running;
	logic [DIV_CNT_W-1:0] count;
	logic [XLEN-1:0] divisor;
	logic [XLEN-1:0] quo;
	logic [XLEN-1:0] rem;
	logic neg_quotient;
	logic neg_remainder;
	logic [XLEN-1:0] num_mag;
	logic [XLEN-1:0] den_mag;
	logic [XLEN:0] shifted;
	logic [XLEN+1:0] trial;

	assign num_mag = (i_signed && i_numerator[XLEN-1]) ? -i_numerator : i_numerator;
	assign den_mag = (i_signed && i_denominator[XLEN-1]) ? -i_denominator : i_denominator;

	// One restoring step
	assign shifted = {rem, quo[XLEN-1]};
	assign trial = {1'b0, shifted} - {2'b00, divisor};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			running <= 1'b0;
			o_done <= 1'b0;
			count <= '0;
		end else if (i_start) begin
			running <= 1'b1;
			o_done <= 1'b0;
			count <= '0;
		end else if (running) begin
			count <= count + 1'b1;
			if (count == DIV_CNT_W'(DIV_STEPS - 1)) begin
				running <= 1'b0;
				o_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_start) begin
			divisor <= den_mag;
			quo <= num_mag;
			rem <= '0;
			// Zero divisor keeps the all-ones quotient unsigned
			neg_quotient <= i_signed && (i_numerator[XLEN-1] ^ i_denominator[XLEN-1]) &&
				(|i_denominator);
			neg_remainder <= i_signed && i_numerator[XLEN-1];
		end else if (running) begin
			if (!trial[XLEN+1]) begin
				rem <= trial[XLEN-1:0];
				quo <= {quo[XLEN-2:0], 1'b1};
			end else begin
				rem <= shifted[XLEN-1:0];
				quo <= {quo[XLEN-2:0], 1'b0};
			end
		end
	end

	// Most negative by minus one wraps back onto the numerator
	assign o_quotient = neg_quotient ? -quo : quo;
	assign o_remainder = neg_remainder ? -rem : rem;

	assert property (@(posedge i_clock) disable iff (i_reset) running |-> !i_start);

endmodule

`default_nettype wire

/* verilog/issue_latch.sv */
`default_nettype none

module issue_latch import execute_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	input wire i_memory_busy,
	input wire [TAG_W-1:0] i_tag,
	input wire [CLASS_W-1:0] i_class,
	input wire [ALUOP_W-1:0] i_alu_op,
	input wire [SEL_W-1:0] i_sel1,
	input wire [SEL_W-1:0] i_sel2,
	input wire [REG_W-1:0] i_rd,
	input wire [XLEN-1:0] i_pc,
	input wire [XLEN-1:0] i_imm,
	input wire [XLEN-1:0] i_rs1,
	input wire [XLEN-1:0] i_rs2,
	input wire [1:0] i_mem_width,
	input wire i_mem_signed,
	output logic o_busy,
	issue_if.issue ex
);

	logic [TAG_W-1:0] last_tag;
	logic accept;

	function automatic logic [XLEN-1:0] select_operand(
		input logic [SEL_W-1:0] sel,
		input logic [XLEN-1:0] rs1,
		input logic [XLEN-1:0] rs2,
		input logic [XLEN-1:0] pc,
		input logic [XLEN-1:0] imm
	);
		logic [XLEN-1:0] value;
		case (sel)
			SEL_ZERO: value = '0;
			SEL_RS1: value = rs1;
			SEL_RS2: value = rs2;
			SEL_PC: value = pc;
			SEL_IMM: value = imm;
			default: value = '0;
		endcase
		return value;
	endfunction

	// New tag, and the slot is free or emptying on this edge
	assign accept = (i_tag != last_tag) && (!ex.pending || ex.done) && !i_memory_busy;

	assign ex.tag = last_tag;

	// Multicycle work in the latch holds off upstream
	assign o_busy = i_memory_busy || (ex.pending && (ex.op_class == CLS_MULDIV) && !ex.done);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			ex.pending <= 1'b0;
			last_tag <= '0;
		end else if (accept) begin
			ex.pending <= 1'b1;
			last_tag <= i_tag;
		end else if (ex.done) begin
			ex.pending <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			ex.op_class <= i_class;
			ex.alu_op <= i_alu_op;
			ex.op1 <= select_operand(i_sel1, i_rs1, i_rs2, i_pc, i_imm);
			ex.op2 <= select_operand(i_sel2, i_rs1, i_rs2, i_pc, i_imm);
			ex.rs1 <= i_rs1;
			ex.rs2 <= i_rs2;
			ex.pc <= i_pc;
			ex.imm <= i_imm;
			ex.rd <= i_rd;
			ex.mem_width <= i_mem_width;
			ex.mem_signed <= i_mem_signed;
		end
	end

	// Memory stall freezes the slot, retire included
	assert property (@(posedge i_clock) disable iff (i_reset)
		i_memory_busy |=> $stable(ex.tag) && $stable(ex.pending));

endmodule

`default_nettype wire

/* verilog/execute_control.sv */
`default_nettype none

module execute_control import execute_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	issue_if.exec ex,
	input wire i_memory_busy,
	output logic o_capture,
	output logic [XLEN-1:0] o_result,
	output logic [REG_W-1:0] o_inst_rd,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic [XLEN-1:0] o_mem_address,
	output logic o_jump_req,
	output logic [XLEN-1:0] o_jump_pc,
	output logic o_fault_req
);

	logic [STATE_W-1:0] state;
	logic mul_ready;
	logic is_muldiv;
	logic is_div;
	logic div_start;
	logic div_done;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] alu_sum;
	logic alu_compare;
	mul_product_u product;
	logic [XLEN-1:0] quotient;
	logic [XLEN-1:0] remainder;

	assign is_muldiv = ex.op_class == CLS_MULDIV;
	assign is_div = ex.alu_op inside {MD_DIV, MD_DIVU, MD_REM, MD_REMU};
	assign div_start = (state == ST_IDLE) && ex.pending && is_muldiv && is_div;

	alu u_alu (
		.i_op(ex.alu_op),
		.i_op1(ex.op1),
		.i_op2(ex.op2),
		.o_result(alu_result),
		.o_sum(alu_sum),
		.o_compare(alu_compare)
	);

	multiplier u_multiplier (
		.i_clock(i_clock),
		.i_sign1(ex.alu_op inside {MD_MUL, MD_MULH, MD_MULHSU}),
		.i_sign2(ex.alu_op inside {MD_MUL, MD_MULH}),
		.i_op1(ex.rs1),
		.i_op2(ex.rs2),
		.o_product(product)
	);

	divider u_divider (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(div_start),
		.i_signed(ex.alu_op inside {MD_DIV, MD_REM}),
		.i_numerator(ex.rs1),
		.i_denominator(ex.rs2),
		.o_done(div_done),
		.o_quotient(quotient),
		.o_remainder(remainder)
	);

	// ============================================================
	// Sequencing
	// ============================================================
	always_comb begin
		case (state)
			ST_IDLE: ex.done = ex.pending && !is_muldiv && !i_memory_busy;
			ST_MUL_WAIT: ex.done = mul_ready && !i_memory_busy;
			ST_DIV_RUN: ex.done = div_done && !i_memory_busy;
			default: ex.done = 1'b0;
		endcase
	end

	assign o_capture = ex.done;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
			mul_ready <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					mul_ready <= 1'b0;
					if (ex.pending && is_muldiv)
						state <= is_div ? ST_DIV_RUN : ST_MUL_WAIT;
				end
				// Second pipeline register fills on the next edge
				ST_MUL_WAIT: begin
					mul_ready <= 1'b1;
					if (ex.done)
						state <= ST_IDLE;
				end
				ST_DIV_RUN: begin
					if (ex.done)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ============================================================
	// Result select
	// ============================================================
	assign o_mem_address = alu_sum;
	assign o_inst_rd = (ex.op_class == CLS_LOAD) ? '0 : ex.rd;

	always_comb begin
		o_result = '0;
		o_jump_req = 1'b0;
		o_jump_pc = alu_sum;
		o_mem_read = 1'b0;
		o_mem_write = 1'b0;
		o_fault_req = 1'b0;
		case (ex.op_class)
			CLS_ARITH, CLS_SHIFT, CLS_COMPARE: o_result = alu_result;
			CLS_JUMP: begin
				o_result = ex.pc + XLEN'(4);
				o_jump_req = 1'b1;
			end
			CLS_BRANCH: begin
				o_jump_req = 1'b1;
				o_jump_pc = alu_compare ? ex.pc + ex.imm : ex.pc + XLEN'(4);
			end
			CLS_LOAD: o_mem_read = 1'b1;
			CLS_STORE: begin
				o_mem_write = 1'b1;
				o_result = ex.rs2;
			end
			CLS_MULDIV: begin
				case (ex.alu_op)
					MD_MUL: o_result = product.half[0];
					MD_MULH, MD_MULHU, MD_MULHSU: o_result = product.half[1];
					MD_DIV, MD_DIVU: o_result = quotient;
					MD_REM, MD_REMU: o_result = remainder;
					default: o_result = '0;
				endcase
			end
			default: o_fault_req = 1'b1;
		endcase
	end

	// Retire only ever drains a latched instruction
	assert property (@(posedge i_clock) disable iff (i_reset) ex.done |-> ex.pending);

endmodule

`default_nettype wire

/* verilog/result_stage.sv */
`default_nettype none

module result_stage import execute_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	input wire i_capture,
	input wire [TAG_W-1:0] i_tag,
	input wire [XLEN-1:0] i_result,
	input wire [REG_W-1:0] i_inst_rd,
	input wire i_mem_read,
	input wire i_mem_write,
	input wire [XLEN-1:0] i_mem_address,
	input wire [1:0] i_mem_width,
	input wire i_mem_signed,
	input wire i_jump_req,
	input wire [XLEN-1:0] i_jump_pc,
	input wire i_fault_req,
	output logic [TAG_W-1:0] o_tag,
	output logic [XLEN-1:0] o_rd_value,
	output logic [REG_W-1:0] o_inst_rd,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic [XLEN-1:0] o_mem_address,
	output logic [1:0] o_mem_width,
	output logic o_mem_signed,
	output logic o_jump,
	output logic [XLEN-1:0] o_jump_pc,
	output logic o_fault
);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_tag <= '0;
			o_mem_read <= 1'b0;
			o_mem_write <= 1'b0;
			o_jump <= 1'b0;
			o_fault <= 1'b0;
		end else begin
			// Jump is a pulse, fault is sticky
			o_jump <= i_capture && i_jump_req;
			if (i_capture) begin
				o_tag <= i_tag;
				o_mem_read <= i_mem_read;
				o_mem_write <= i_mem_write;
				if (i_fault_req)
					o_fault <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_capture) begin
			o_rd_value <= i_result;
			o_inst_rd <= i_inst_rd;
			o_mem_address <= i_mem_address;
			o_mem_width <= i_mem_width;
			o_mem_signed <= i_mem_signed;
			o_jump_pc <= i_jump_pc;
		end
	end

endmodule

`default_nettype wire

/* verilog/execute_top.sv */
`default_nettype none

module execute_top import execute_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	input wire i_memory_busy,
	input wire [TAG_W-1:0] i_tag,
	input wire [CLASS_W-1:0] i_class,
	input wire [ALUOP_W-1:0] i_alu_op,
	input wire [SEL_W-1:0] i_sel1,
	input wire [SEL_W-1:0] i_sel2,
	input wire [REG_W-1:0] i_rd,
	input wire [XLEN-1:0] i_pc,
	input wire [XLEN-1:0] i_imm,
	input wire [XLEN-1:0] i_rs1,
	input wire [XLEN-1:0] i_rs2,
	input wire [1:0] i_mem_width,
	input wire i_mem_signed,
	output logic o_busy,
	output logic [TAG_W-1:0] o_tag,
	output logic [XLEN-1:0] o_rd_value,
	output logic [REG_W-1:0] o_inst_rd,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic [XLEN-1:0] o_mem_address,
	output logic [1:0] o_mem_width,
	output logic o_mem_signed,
	output logic o_jump,
	output logic [XLEN-1:0] o_jump_pc,
	output logic o_fault
);

	logic capture;
	logic [XLEN-1:0] result;
	logic [REG_W-1:0] inst_rd;
	logic mem_read;
	logic mem_write;
	logic [XLEN-1:0] mem_address;
	logic jump_req;
	logic [XLEN-1:0] jump_pc;
	logic fault_req;

	issue_if ex_bus ();

	issue_latch u_issue_latch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_memory_busy(i_memory_busy),
		.i_tag(i_tag),
		.i_class(i_class),
		.i_alu_op(i_alu_op),
		.i_sel1(i_sel1),
		.i_sel2(i_sel2),
		.i_rd(i_rd),
		.i_pc(i_pc),
		.i_imm(i_imm),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.i_mem_width(i_mem_width),
		.i_mem_signed(i_mem_signed),
		.o_busy(o_busy),
		.ex(ex_bus.issue)
	);

	execute_control u_execute_control (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.ex(ex_bus.exec),
		.i_memory_busy(i_memory_busy),
		.o_capture(capture),
		.o_result(result),
		.o_inst_rd(inst_rd),
		.o_mem_read(mem_read),
		.o_mem_write(mem_write),
		.o_mem_address(mem_address),
		.o_jump_req(jump_req),
		.o_jump_pc(jump_pc),
		.o_fault_req(fault_req)
	);

	result_stage u_result_stage (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_capture(capture),
		.i_tag(ex_bus.tag),
		.i_result(result),
		.i_inst_rd(inst_rd),
		.i_mem_read(mem_read),
		.i_mem_write(mem_write),
		.i_mem_address(mem_address),
		.i_mem_width(ex_bus.mem_width),
		.i_mem_signed(ex_bus.mem_signed),
		.i_jump_req(jump_req),
		.i_jump_pc(jump_pc),
		.i_fault_req(fault_req),
		.o_tag(o_tag),
		.o_rd_value(o_rd_value),
		.o_inst_rd(o_inst_rd),
		.o_mem_read(o_mem_read),
		.o_mem_write(o_mem_write),
		.o_mem_address(o_mem_address),
		.o_mem_width(o_mem_width),
		.o_mem_signed(o_mem_signed),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_fault(o_fault)
	);

endmodule

`default_nettype wire

/* tb/execute_model.svh */
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

// Expected outcome of one accepted instruction
typedef struct {
	logic [TAG_W-1:0] tag;
	logic [XLEN-1:0] result;
	logic [REG_W-1:0] inst_rd;
	logic mem_read;
	logic mem_write;
	logic [XLEN-1:0] mem_address;
	logic [1:0] mem_width;
	logic mem_signed;
	logic jump;
	logic [XLEN-1:0] jump_pc;
	logic fault;
	bit fixed_latency;
	int accept_edge;
	int stalls;
} expect_t;

// Oldest accepted instruction at the front
expect_t expect_q[$];

function automatic logic [XLEN-1:0] model_operand(
	input logic [SEL_W-1:0] sel,
	input logic [XLEN-1:0] rs1,
	input logic [XLEN-1:0] rs2,
	input logic [XLEN-1:0] pc,
	input logic [XLEN-1:0] imm
);
	logic [XLEN-1:0] v;
	case (sel)
		SEL_RS1: v = rs1;
		SEL_RS2: v = rs2;
		SEL_PC: v = pc;
		SEL_IMM: v = imm;
		default: v = '0;
	endcase
	return v;
endfunction

function automatic logic model_compare(
	input logic [ALUOP_W-1:0] op,
	input logic [XLEN-1:0] a,
	input logic [XLEN-1:0] b
);
	logic c;
	case (op)
		ALU_SLT: c = $signed(a) < $signed(b);
		ALU_SLTU: c = a < b;
		ALU_EQ: c = a == b;
		ALU_NE: c = a != b;
		ALU_GE: c = !($signed(a) < $signed(b));
		ALU_GEU: c = !(a < b);
		default: c = 1'b0;
	endcase
	return c;
endfunction

function automatic logic [XLEN-1:0] model_alu(
	input logic [ALUOP_W-1:0] op,
	input logic [XLEN-1:0] a,
	input logic [XLEN-1:0] b
);
	logic [XLEN-1:0] v;
	case (op)
		ALU_ADD: v = a + b;
		ALU_SUB: v = a - b;
		ALU_AND: v = a & b;
		ALU_OR: v = a | b;
		ALU_XOR: v = a ^ b;
		ALU_SLL: v = a << b[4:0];
		ALU_SRL: v = a >> b[4:0];
		ALU_SRA: v = $signed(a) >>> b[4:0];
		ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU:
			v = XLEN'(model_compare(op, a, b));
		default: v = '0;
	endcase
	return v;
endfunction

function automatic logic [XLEN-1:0] model_muldiv(
	input logic [ALUOP_W-1:0] op,
	input logic [XLEN-1:0] a,
	input logic [XLEN-1:0] b
);
	logic [2*XLEN-1:0] prod;
	logic [XLEN-1:0] v;
	logic overflow;
	int sa;
	int sb;
	sa = a;
	sb = b;
	overflow = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
	prod = '0;
	v = '0;
	case (op)
		MD_MUL: begin
			prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
			v = prod[XLEN-1:0];
		end
		MD_MULH: begin
			prod = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
			v = prod[2*XLEN-1:XLEN];
		end
		MD_MULHU: begin
			prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
			v = prod[2*XLEN-1:XLEN];
		end
		MD_MULHSU: begin
			prod = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
			v = prod[2*XLEN-1:XLEN];
		end
		MD_DIV: begin
			if (b == '0)
				v = '1;
			else if (overflow)
				v = a;
			else
				v = sa / sb;
		end
		MD_DIVU: v = (b == '0) ? '1 : a / b;
		MD_REM: begin
			if (b == '0)
				v = a;
			else if (overflow)
				v = '0;
			else
				v = sa % sb;
		end
		MD_REMU: v = (b == '0) ? a : a % b;
		default: v = '0;
	endcase
	return v;
endfunction

function automatic expect_t model_expect(
	input logic [TAG_W-1:0] tag,
	input logic [CLASS_W-1:0] cls,
	input logic [ALUOP_W-1:0] op,
	input logic [SEL_W-1:0] sel1,
	input logic [SEL_W-1:0] sel2,
	input logic [REG_W-1:0] rd,
	input logic [XLEN-1:0] pc,
	input logic [XLEN-1:0] imm,
	input logic [XLEN-1:0] rs1,
	input logic [XLEN-1:0] rs2,
	input logic [1:0] mem_width,
	input logic mem_signed
);
	expect_t e;
	logic [XLEN-1:0] op1;
	logic [XLEN-1:0] op2;
	op1 = model_operand(sel1, rs1, rs2, pc, imm);
	op2 = model_operand(sel2, rs1, rs2, pc, imm);
	e.tag = tag;
	e.result = '0;
	e.inst_rd = rd;
	e.mem_read = 1'b0;
	e.mem_write = 1'b0;
	e.mem_address = op1 + op2;
	e.mem_width = mem_width;
	e.mem_signed = mem_signed;
	e.jump = 1'b0;
	e.jump_pc = '0;
	e.fault = 1'b0;
	e.fixed_latency = 1'b1;
	e.accept_edge = 0;
	e.stalls = 0;
	case (cls)
		CLS_ARITH, CLS_SHIFT, CLS_COMPARE: e.result = model_alu(op, op1, op2);
		CLS_JUMP: begin
			e.result = pc + XLEN'(4);
			e.jump = 1'b1;
			e.jump_pc = op1 + op2;
		end
		CLS_BRANCH: begin
			e.jump = 1'b1;
			e.jump_pc = model_compare(op, op1, op2) ? pc + imm : pc + XLEN'(4);
		end
		CLS_LOAD: begin
			e.mem_read = 1'b1;
			e.inst_rd = '0;
		end
		CLS_STORE: begin
			e.mem_write = 1'b1;
			e.result = rs2;
		end
		CLS_MULDIV: begin
			e.result = model_muldiv(op, rs1, rs2);
			e.fixed_latency = 1'b0;
		end
		default: e.fault = 1'b1;
	endcase
	return e;
endfunction

`endif

/* tb/tb_execute.sv */
`default_nettype none

module tb_execute import execute_pkg::*; ();

	localparam int CLOCK_PERIOD = 20;
	localparam int NUM_INST = 400;
	localparam int WATCHDOG_CYCLES = (NUM_INST + 1) * 40;

	logic i_clock;
	logic i_reset;
	logic i_memory_busy;
	logic [TAG_W-1:0] i_tag;
	logic [CLASS_W-1:0] i_class;
	logic [ALUOP_W-1:0] i_alu_op;
	logic [SEL_W-1:0] i_sel1;
	logic [SEL_W-1:0] i_sel2;
	logic [REG_W-1:0] i_rd;
	logic [XLEN-1:0] i_pc;
	logic [XLEN-1:0] i_imm;
	logic [XLEN-1:0] i_rs1;
	logic [XLEN-1:0] i_rs2;
	logic [1:0] i_mem_width;
	logic i_mem_signed;
	logic o_busy;
	logic [TAG_W-1:0] o_tag;
	logic [XLEN-1:0] o_rd_value;
	logic [REG_W-1:0] o_inst_rd;
	logic o_mem_read;
	logic o_mem_write;
	logic [XLEN-1:0] o_mem_address;
	logic [1:0] o_mem_width;
	logic o_mem_signed;
	logic o_jump;
	logic [XLEN-1:0] o_jump_pc;
	logic o_fault;

	integer seed;
	int value_errors;
	int other_errors;
	int accepted;
	int edge_count;
	int busy_left;
	bit reset_done;
	bit busy_prev;
	bit fault_expected;
	logic [TAG_W-1:0] accepted_tag;
	logic [TAG_W-1:0] last_o_tag;

	`include "execute_model.svh"

	execute_top uut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_memory_busy(i_memory_busy),
		.i_tag(i_tag),
		.i_class(i_class),
		.i_alu_op(i_alu_op),
		.i_sel1(i_sel1),
		.i_sel2(i_sel2),
		.i_rd(i_rd),
		.i_pc(i_pc),
		.i_imm(i_imm),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.i_mem_width(i_mem_width),
		.i_mem_signed(i_mem_signed),
		.o_busy(o_busy),
		.o_tag(o_tag),
		.o_rd_value(o_rd_value),
		.o_inst_rd(o_inst_rd),
		.o_mem_read(o_mem_read),
		.o_mem_write(o_mem_write),
		.o_mem_address(o_mem_address),
		.o_mem_width(o_mem_width),
		.o_mem_signed(o_mem_signed),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_fault(o_fault)
	);

	initial begin
		i_clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) i_clock = ~i_clock;
	end

	always @(posedge i_clock) begin
		edge_count <= edge_count + 1;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("watchdog expired with %0d instructions still outstanding", expect_q.size());
		$display("TESTS FAILED");
		$finish;
	end

	// ============================================================
	// Compare tasks
	// ============================================================
	task automatic check_word(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] want);
		if (got !== want) begin
			value_errors++;
			$display("ERR %0t %s: got %h expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_tag(input string name, input logic [TAG_W-1:0] got,
		input logic [TAG_W-1:0] want);
		if (got !== want) begin
			value_errors++;
			$display("ERR %0t %s: got %0d expected %0d", $time, name, got, want);
		end
	endtask

	task automatic check_reg(input string name, input logic [REG_W-1:0] got,
		input logic [REG_W-1:0] want);
		if (got !== want) begin
			value_errors++;
			$display("ERR %0t %s: got %0d expected %0d", $time, name, got, want);
		end
	endtask

	task automatic check_width(input string name, input logic [1:0] got,
		input logic [1:0] want);
		if (got !== want) begin
			value_errors++;
			$display("ERR %0t %s: got %0d expected %0d", $time, name, got, want);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			value_errors++;
			$display("ERR %0t %s: got %b expected %b", $time, name, got, want);
		end
	endtask

	task automatic compare_retire(input expect_t e);
		check_tag("o_tag", o_tag, e.tag);
		check_word("o_rd_value", o_rd_value, e.result);
		check_reg("o_inst_rd", o_inst_rd, e.inst_rd);
		check_bit("o_mem_read", o_mem_read, e.mem_read);
		check_bit("o_mem_write", o_mem_write, e.mem_write);
		check_width("o_mem_width", o_mem_width, e.mem_width);
		check_bit("o_mem_signed", o_mem_signed, e.mem_signed);
		if (e.mem_read || e.mem_write)
			check_word("o_mem_address", o_mem_address, e.mem_address);
		check_bit("o_jump", o_jump, e.jump);
		if (e.jump)
			check_word("o_jump_pc", o_jump_pc, e.jump_pc);
		if (e.fixed_latency && edge_count != e.accept_edge + 1 + e.stalls) begin
			value_errors++;
			$display("ERR %0t retire edge: got %0d expected %0d", $time, edge_count,
				e.accept_edge + 1 + e.stalls);
		end
		if (e.fault)
			fault_expected = 1'b1;
	endtask

	// Outputs are settled at the falling edge
	always @(negedge i_clock) begin
		expect_t e;
		if (reset_done) begin
			if (o_tag != last_o_tag) begin
				if (expect_q.size() == 0) begin
					other_errors++;
					$display("tag %0d retired with no instruction outstanding", o_tag);
				end else begin
					e = expect_q.pop_front();
					compare_retire(e);
				end
				if (busy_prev)
					check_tag("o_tag", o_tag, last_o_tag);
			end else begin
				check_bit("o_jump", o_jump, 1'b0);
			end
			check_bit("o_fault", o_fault, fault_expected);
			if (i_memory_busy) begin
				check_bit("o_busy", o_busy, 1'b1);
				foreach (expect_q[i])
					expect_q[i].stalls++;
			end
			last_o_tag = o_tag;
			busy_prev = i_memory_busy;
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================
	task automatic pick_value(output logic [XLEN-1:0] v);
		logic [XLEN-1:0] r;
		r = $random(seed);
		case (r[2:0])
			3'd0: v = '0;
			3'd1: v = {1'b1, {(XLEN-1){1'b0}}};
			3'd2: v = '1;
			3'd3: v = XLEN'(1);
			default: v = $random(seed);
		endcase
	endtask

	task automatic present_instruction(input bit invalid);
		logic [XLEN-1:0] r;
		r = $random(seed);
		i_tag = i_tag + 1'b1;
		if (invalid)
			i_class = CLASS_W'(8) | CLASS_W'(r[2:0]);
		else if (r[3:2] == 2'b11)
			i_class = CLS_MULDIV;
		else
			i_class = CLASS_W'(r[2:0]);
		i_alu_op = (i_class == CLS_MULDIV) ? ALUOP_W'(r[6:4]) : r[7:4];
		i_sel1 = r[10:8];
		i_sel2 = r[13:11];
		i_rd = r[18:14];
		i_mem_width = r[20:19];
		i_mem_signed = r[21];
		pick_value(i_rs1);
		pick_value(i_rs2);
		// Steer some divides onto the signed overflow case
		if (i_class == CLS_MULDIV && r[24:23] == 2'b00) begin
			i_rs1 = {1'b1, {(XLEN-1){1'b0}}};
			i_rs2 = '1;
		end
		i_pc = $random(seed);
		i_imm = $random(seed);
	endtask

	task automatic drive_memory_busy();
		logic [XLEN-1:0] r;
		r = $random(seed);
		if (busy_left > 0) begin
			busy_left--;
			i_memory_busy = 1'b1;
		end else if (r[3:0] == 4'd0) begin
			i_memory_busy = 1'b1;
			busy_left = int'(r[5:4]);
		end else begin
			i_memory_busy = 1'b0;
		end
	endtask

	// One clock of issue, with acceptance judged before the edge
	task automatic issue_step(input bit more, input bit invalid);
		expect_t e;
		bit take;
		@(negedge i_clock);
		take = !o_busy && (i_tag != accepted_tag);
		@(posedge i_clock);
		#2;
		if (take) begin
			e = model_expect(i_tag, i_class, i_alu_op, i_sel1, i_sel2, i_rd, i_pc, i_imm,
				i_rs1, i_rs2, i_mem_width, i_mem_signed);
			e.accept_edge = edge_count;
			expect_q.push_back(e);
			accepted_tag = i_tag;
			accepted++;
			if (more)
				present_instruction(invalid);
		end
		drive_memory_busy();
	endtask

	initial begin
		seed = 32'hb16d_4418;
		i_reset = 1'b1;
		i_memory_busy = 1'b0;
		i_tag = '0;
		i_class = '0;
		i_alu_op = '0;
		i_sel1 = '0;
		i_sel2 = '0;
		i_rd = '0;
		i_pc = '0;
		i_imm = '0;
		i_rs1 = '0;
		i_rs2 = '0;
		i_mem_width = '0;
		i_mem_signed = 1'b0;
		value_errors = 0;
		other_errors = 0;
		accepted = 0;
		edge_count = 0;
		busy_left = 0;
		reset_done = 1'b0;
		busy_prev = 1'b0;
		fault_expected = 1'b0;
		accepted_tag = '0;
		last_o_tag = '0;

		repeat (2) @(posedge i_clock);
		#2;
		i_reset = 1'b0;
		reset_done = 1'b1;

		present_instruction(1'b0);
		while (accepted < NUM_INST)
			issue_step(accepted + 1 < NUM_INST, 1'b0);
		while (expect_q.size() != 0)
			issue_step(1'b0, 1'b0);

		// Invalid class last, then o_fault must stay up
		present_instruction(1'b1);
		while (accepted < NUM_INST + 1)
			issue_step(1'b0, 1'b0);
		while (expect_q.size() != 0)
			issue_step(1'b0, 1'b0);
		repeat (10) issue_step(1'b0, 1'b0);
		if (!fault_expected) begin
			other_errors++;
			$display("the invalid class instruction never retired");
		end

		$display("instructions: %0d, value errors: %0d, other errors: %0d", accepted,
			value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+tb
verilog/execute_pkg.sv
verilog/issue_if.sv
verilog/alu.sv
verilog/multiplier.sv
verilog/divider.sv
verilog/issue_latch.sv
verilog/execute_control.sv
verilog/result_stage.sv
verilog/execute_top.sv
tb/tb_execute.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_execute

output=$(./obj_dir/Vtb_execute)
echo "$output"

if echo "$output" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1
